/* axi_pkg.sv */
// Field widths and channel payloads of the external master port.
// Only single-beat transfers are issued, so len stays zero and last stays high.
package axi_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int strb_w = data_w / 8;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;
    localparam logic [1:0] burst_incr  = 2'b01;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [3:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [3:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

endpackage

/* core_bus_pkg.sv */
// Core-side request and response words shared by the ports, buffers and bus interface.
package core_bus_pkg;

    localparam logic src_fetch = 1'b0;
    localparam logic src_data  = 1'b1;

    localparam int fifo_depth = 2;

    // size codes are the AXI size encoding.
    localparam logic [2:0] size_byte = 3'd0;
    localparam logic [2:0] size_half = 3'd1;
    localparam logic [2:0] size_word = 3'd2;

    typedef struct packed {
        logic        src;
        logic        write;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [2:0]  size;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        src;
        logic [31:0] rdata;
        logic        err;
    } mem_rsp_t;

endpackage

/* req_fifo.sv */
`timescale 1ns/1ps
// A push into a full buffer is dropped, so the producer has to watch full.
module req_fifo import core_bus_pkg::*; #(
    parameter type payload_t = mem_req_t,
    parameter int  depth     = fifo_depth
) (
    input  logic     aclk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == cnt_w'(depth));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leaves the level unchanged.
            endcase
        end
    end

endmodule

/* fetch_port.sv */
`timescale 1ns/1ps
// Word reads only; inst_addr is passed on as given, alignment is the core's job.
module fetch_port import core_bus_pkg::*; (
    input  logic        aclk,
    input  logic        reset,
    input  logic        inst_en,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    output logic        inst_stall,
    output logic        inst_err,
    output logic        push,
    output mem_req_t    push_data,
    input  logic        full,
    input  logic        rsp_valid,
    input  mem_rsp_t    rsp
);

    typedef enum logic {st_idle, st_wait} state_t;

    state_t state;
    logic   take;

    // the shared response bus carries both sources, only ours ends the wait.
    assign take       = (state == st_wait) && rsp_valid && (rsp.src == src_fetch);
    assign inst_stall = inst_en && !take;
    assign inst_rdata = rsp.rdata;
    assign inst_err   = take && rsp.err;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= st_idle;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                st_idle: begin
                    if (inst_en && !full) begin
                        push  <= 1'b1;
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (take) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // request is captured while idle and held through the push cycle.
    always_ff @(posedge aclk) begin
        if (state == st_idle) begin
            push_data.src   <= src_fetch;
            push_data.write <= 1'b0;
            push_data.addr  <= inst_addr;
            push_data.strb  <= 4'b0000;
            push_data.size  <= size_word;
            push_data.wdata <= '0;
        end
    end

endmodule

/* data_port.sv */
`timescale 1ns/1ps
// data_wen must already fit data_size and the low address bits; nothing here checks it.
module data_port import core_bus_pkg::*; (
    input  logic        aclk,
    input  logic        reset,
    input  logic        data_en,
    input  logic [3:0]  data_wen,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    input  logic [2:0]  data_size,
    output logic [31:0] data_rdata,
    output logic        data_stall,
    output logic        data_err,
    output logic        push,
    output mem_req_t    push_data,
    input  logic        full,
    input  logic        rsp_valid,
    input  mem_rsp_t    rsp
);

    typedef enum logic {st_idle, st_wait} state_t;

    state_t state;
    logic   take;
    logic   is_write;

    assign is_write   = |data_wen; // any strobe set makes it a write.
    assign take       = (state == st_wait) && rsp_valid && (rsp.src == src_data);
    assign data_stall = data_en && !take;
    assign data_rdata = rsp.rdata;
    assign data_err   = take && rsp.err;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= st_idle;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                st_idle: begin
                    if (data_en && !full) begin
                        push  <= 1'b1;
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (take) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == st_idle) begin
            push_data.src   <= src_data;
            push_data.write <= is_write;
            push_data.addr  <= data_addr;
            push_data.strb  <= data_wen;
            push_data.size  <= data_size;
            push_data.wdata <= data_wdata;
        end
    end

endmodule

/* bus_interface.sv */
`timescale 1ns/1ps
// One external transaction at a time; the AXI id carries the source in its low bit.
// Reads and writes are single beats, so rlast is not looked at.
module bus_interface import axi_pkg::*; import core_bus_pkg::*; (
    input  logic     aclk,
    input  logic     reset,
    input  logic     fetch_not_empty,
    input  mem_req_t fetch_head,
    output logic     fetch_pop,
    input  logic     data_not_empty,
    input  mem_req_t data_head,
    output logic     data_pop,
    output axi_ar_t  ar,
    output logic     arvalid,
    input  logic     arready,
    input  axi_r_t   r,
    input  logic     rvalid,
    output logic     rready,
    output axi_aw_t  aw,
    output logic     awvalid,
    input  logic     awready,
    output axi_w_t   w,
    output logic     wvalid,
    input  logic     wready,
    input  axi_b_t   b,
    input  logic     bvalid,
    output logic     bready,
    output logic     rsp_valid,
    output mem_rsp_t rsp
);

    typedef enum logic [1:0] {st_idle, st_addr, st_rresp, st_bresp} state_t;

    state_t   state;
    logic     last_src;     // source that won the previous grant.
    logic     pick_data;
    mem_req_t sel_head;
    mem_req_t cur;
    logic     aw_done;
    logic     w_done;

    // with both heads waiting the source that did not go last wins.
    assign pick_data = data_not_empty && (!fetch_not_empty || last_src == src_fetch);
    assign sel_head  = pick_data ? data_head : fetch_head;
    assign fetch_pop = (state == st_idle) && fetch_not_empty && !pick_data;
    assign data_pop  = (state == st_idle) && pick_data;

    assign ar.id    = id_w'(cur.src);
    assign ar.addr  = cur.addr;
    assign ar.len   = '0;
    assign ar.size  = cur.size;
    assign ar.burst = burst_incr;

    assign aw.id    = id_w'(cur.src);
    assign aw.addr  = cur.addr;
    assign aw.len   = '0;
    assign aw.size  = cur.size;
    assign aw.burst = burst_incr;

    assign w.data = cur.wdata;
    assign w.strb = cur.strb;
    assign w.last = 1'b1;

    assign rready = (state == st_rresp);
    assign bready = (state == st_bresp);

    // a write channel counts as done once its handshake has happened or happens now.
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= st_idle;
            last_src  <= src_data;
            arvalid   <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (fetch_pop || data_pop) begin
                        last_src <= pick_data ? src_data : src_fetch;
                        arvalid  <= !sel_head.write;
                        awvalid  <= sel_head.write;
                        wvalid   <= sel_head.write;
                        state    <= st_addr;
                    end
                end
                st_addr: begin
                    if (!cur.write) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            state   <= st_rresp;
                        end
                    end else begin
                        if (awready) begin
                            awvalid <= 1'b0;
                        end
                        if (wready) begin
                            wvalid <= 1'b0;
                        end
                        if (aw_done && w_done) begin
                            state <= st_bresp;
                        end
                    end
                end
                st_rresp: begin
                    if (rvalid) begin
                        rsp_valid <= 1'b1;
                        state     <= st_idle;
                    end
                end
                st_bresp: begin
                    if (bvalid) begin
                        rsp_valid <= 1'b1;
                        state     <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == st_idle) begin
            cur <= sel_head; // frozen for as long as the transaction runs.
        end
        if (rvalid && rready) begin
            rsp.src   <= r.id[0];
            rsp.rdata <= r.data;
            rsp.err   <= (r.resp != resp_okay);
        end else if (bvalid && bready) begin
            rsp.src   <= b.id[0];
            rsp.rdata <= '0;
            rsp.err   <= (b.resp != resp_okay);
        end
    end

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps
// Fetch and data requests share one AXI master port, one beat per transfer.
module mem_subsys_top import axi_pkg::*; import core_bus_pkg::*; (
    input  logic        aclk,
    input  logic        reset,

    input  logic        inst_en,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    output logic        inst_stall,
    output logic        inst_err,

    input  logic        data_en,
    input  logic [3:0]  data_wen,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    input  logic [2:0]  data_size,
    output logic [31:0] data_rdata,
    output logic        data_stall,
    output logic        data_err,

    output axi_ar_t     m_ar,
    output logic        m_arvalid,
    input  logic        m_arready,
    input  axi_r_t      m_r,
    input  logic        m_rvalid,
    output logic        m_rready,
    output axi_aw_t     m_aw,
    output logic        m_awvalid,
    input  logic        m_awready,
    output axi_w_t      m_w,
    output logic        m_wvalid,
    input  logic        m_wready,
    input  axi_b_t      m_b,
    input  logic        m_bvalid,
    output logic        m_bready
);

    logic     reset_q;
    logic     fetch_push;
    mem_req_t fetch_push_data;
    logic     fetch_full;
    logic     fetch_not_empty;
    mem_req_t fetch_head;
    logic     fetch_pop;
    logic     data_push;
    mem_req_t data_push_data;
    logic     data_full;
    logic     data_not_empty;
    mem_req_t data_head;
    logic     data_pop;
    logic     rsp_valid;
    mem_rsp_t rsp;

    // the incoming reset is retimed once before it reaches any block.
    always_ff @(posedge aclk) begin
        reset_q <= reset;
    end

    fetch_port fetch_port_inst (
        .aclk       (aclk           ),
        .reset      (reset_q        ),
        .inst_en    (inst_en        ),
        .inst_addr  (inst_addr      ),
        .inst_rdata (inst_rdata     ),
        .inst_stall (inst_stall     ),
        .inst_err   (inst_err       ),
        .push       (fetch_push     ),
        .push_data  (fetch_push_data),
        .full       (fetch_full     ),
        .rsp_valid  (rsp_valid      ),
        .rsp        (rsp            )
    );

    data_port data_port_inst (
        .aclk       (aclk          ),
        .reset      (reset_q       ),
        .data_en    (data_en       ),
        .data_wen   (data_wen      ),
        .data_addr  (data_addr     ),
        .data_wdata (data_wdata    ),
        .data_size  (data_size     ),
        .data_rdata (data_rdata    ),
        .data_stall (data_stall    ),
        .data_err   (data_err      ),
        .push       (data_push     ),
        .push_data  (data_push_data),
        .full       (data_full     ),
        .rsp_valid  (rsp_valid     ),
        .rsp        (rsp           )
    );

    req_fifo #(.payload_t(mem_req_t)) fetch_fifo_inst (
        .aclk      (aclk           ),
        .reset     (reset_q        ),
        .push      (fetch_push     ),
        .push_data (fetch_push_data),
        .full      (fetch_full     ),
        .pop       (fetch_pop      ),
        .head      (fetch_head     ),
        .not_empty (fetch_not_empty)
    );

    req_fifo #(.payload_t(mem_req_t)) data_fifo_inst (
        .aclk      (aclk          ),
        .reset     (reset_q       ),
        .push      (data_push     ),
        .push_data (data_push_data),
        .full      (data_full     ),
        .pop       (data_pop      ),
        .head      (data_head     ),
        .not_empty (data_not_empty)
    );

    bus_interface bus_interface_inst (
        .aclk            (aclk           ),
        .reset           (reset_q        ),
        .fetch_not_empty (fetch_not_empty),
        .fetch_head      (fetch_head     ),
        .fetch_pop       (fetch_pop      ),
        .data_not_empty  (data_not_empty ),
        .data_head       (data_head      ),
        .data_pop        (data_pop       ),
        .ar              (m_ar           ),
        .arvalid         (m_arvalid      ),
        .arready         (m_arready      ),
        .r               (m_r            ),
        .rvalid          (m_rvalid       ),
        .rready          (m_rready       ),
        .aw              (m_aw           ),
        .awvalid         (m_awvalid      ),
        .awready         (m_awready      ),
        .w               (m_w            ),
        .wvalid          (m_wvalid       ),
        .wready          (m_wready       ),
        .b               (m_b            ),
        .bvalid          (m_bvalid       ),
        .bready          (m_bready       ),
        .rsp_valid       (rsp_valid      ),
        .rsp             (rsp            )
    );

endmodule

/* tb_axi_slave.sv */
`timescale 1ns/1ps
// Single-outstanding AXI slave memory with random ready and response delays of 0 to 3 cycles.
// Addresses with the top bit set answer slverr and are never written.
module tb_axi_slave import axi_pkg::*; (
    input  logic    aclk,
    input  logic    reset,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready
);

    logic [31:0] mem [logic [29:0]]; // keyed by word address.
    int          ar_wait;
    int          aw_wait;
    int          w_wait;
    int          r_wait;
    int          b_wait;
    logic        rd_busy;
    logic        got_aw;
    logic        got_w;
    axi_ar_t     rd_req;
    axi_aw_t     wr_req;
    axi_w_t      wr_data;
    logic [31:0] wr_word;

    // unwritten words hold a pattern built from the whole address.
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[15:2], 2'b00, a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    always @(posedge aclk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_busy <= 1'b0;
            r       <= '0;
            ar_wait <= $urandom % 4;
            r_wait  <= 0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_req  <= ar;
                r_wait  <= $urandom % 4;
                ar_wait <= $urandom % 4;
            end else if (arvalid && !rd_busy) begin
                if (ar_wait == 0) arready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (rd_busy && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    r.id   <= rd_req.id;
                    r.data <= read_word(rd_req.addr);
                    r.resp <= rd_req.addr[31] ? resp_slverr : resp_okay;
                    r.last <= 1'b1;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
            end
        end
    end

    always @(posedge aclk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            got_aw  <= 1'b0;
            got_w   <= 1'b0;
            b       <= '0;
            aw_wait <= $urandom % 4;
            w_wait  <= $urandom % 4;
            b_wait  <= $urandom % 4;
        end else begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                got_aw  <= 1'b1;
                wr_req  <= aw;
                aw_wait <= $urandom % 4;
            end else if (awvalid && !got_aw) begin
                if (aw_wait == 0) awready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                got_w   <= 1'b1;
                wr_data <= w;
                w_wait  <= $urandom % 4;
            end else if (wvalid && !got_w) begin
                if (w_wait == 0) wready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            if (got_aw && got_w && !bvalid) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                    b.id   <= wr_req.id;
                    b.resp <= wr_req.addr[31] ? resp_slverr : resp_okay;
                    if (!wr_req.addr[31]) begin
                        wr_word = read_word(wr_req.addr);
                        for (int i = 0; i < 4; i++) begin
                            if (wr_data.strb[i]) wr_word[8*i +: 8] = wr_data.data[8*i +: 8];
                        end
                        mem[wr_req.addr[31:2]] = wr_word;
                    end
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                got_aw <= 1'b0;
                got_w  <= 1'b0;
                b_wait <= $urandom % 4;
            end
        end
    end

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps
// Core-side stimulus on the falling edge; fetch and data use disjoint address ranges.
module tb_mem_subsys import axi_pkg::*; import core_bus_pkg::*; ();

    localparam int n_req    = 32;
    localparam int max_wait = 60; // cycles one request may take, contention included.

    logic        aclk;
    logic        reset;
    logic        inst_en;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_stall;
    logic        inst_err;
    logic        data_en;
    logic [3:0]  data_wen;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [2:0]  data_size;
    logic [31:0] data_rdata;
    logic        data_stall;
    logic        data_err;
    axi_ar_t     m_ar;
    axi_r_t      m_r;
    axi_aw_t     m_aw;
    axi_w_t      m_w;
    axi_b_t      m_b;
    logic        m_arvalid;
    logic        m_arready;
    logic        m_rvalid;
    logic        m_rready;
    logic        m_awvalid;
    logic        m_awready;
    logic        m_wvalid;
    logic        m_wready;
    logic        m_bvalid;
    logic        m_bready;

    int          value_errs;
    int          proto_errs;
    logic [31:0] shadow [logic [29:0]];
    logic [2:0]  exp_size;
    logic [3:0]  exp_wen;
    logic        last_pop;
    logic        prev_arvalid;
    logic        prev_arready;
    logic        prev_awvalid;
    logic        prev_awready;
    logic        prev_wvalid;
    logic        prev_wready;
    axi_ar_t     prev_ar;
    axi_aw_t     prev_aw;
    axi_w_t      prev_w;

    mem_subsys_top mem_subsys_top_inst (.*);

    tb_axi_slave slave_inst (
        .aclk    (aclk     ),
        .reset   (reset    ),
        .ar      (m_ar     ),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .r       (m_r      ),
        .rvalid  (m_rvalid ),
        .rready  (m_rready ),
        .aw      (m_aw     ),
        .awvalid (m_awvalid),
        .awready (m_awready),
        .w       (m_w      ),
        .wvalid  (m_wvalid ),
        .wready  (m_wready ),
        .b       (m_b      ),
        .bvalid  (m_bvalid ),
        .bready  (m_bready )
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // the expected word is the last write merged by strobes, or else the slave's fill pattern.
    function automatic logic [31:0] expect_word(input logic [31:0] a);
        if (shadow.exists(a[31:2])) return shadow[a[31:2]];
        return {a[15:2], 2'b00, a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] rand_addr(input logic [31:0] base);
        return base | ($urandom() & 32'h0000_07fc);
    endfunction

    task automatic fetch_read(input logic [31:0] addr);
        logic [31:0] exp;
        int          n;
        exp = expect_word(addr);
        n   = 0;
        @(negedge aclk);
        inst_en   = 1'b1;
        inst_addr = addr;
        do begin
            @(negedge aclk);
            n++;
        end while (inst_stall && n < max_wait);
        if (n >= max_wait) begin
            proto_errs++;
            $display("fetch read of %h never got a response", addr);
        end else begin
            assert (inst_err == addr[31]) else begin
                value_errs++;
                $display("Fail inst_err: got %h expected %h", inst_err, addr[31]);
            end
            assert (addr[31] || inst_rdata == exp) else begin
                value_errs++;
                $display("Fail inst_rdata: got %h expected %h", inst_rdata, exp);
            end
        end
        inst_en = 1'b0;
    endtask

    task automatic data_access(input logic [31:0] addr, input logic [3:0] wen,
                               input logic [31:0] wdata, input logic [2:0] size);
        logic [31:0] exp;
        int          n;
        exp = expect_word(addr);
        n   = 0;
        @(negedge aclk);
        exp_size   = size;
        exp_wen    = wen;
        data_en    = 1'b1;
        data_addr  = addr;
        data_wen   = wen;
        data_wdata = wdata;
        data_size  = size;
        do begin
            @(negedge aclk);
            n++;
        end while (data_stall && n < max_wait);
        if (n >= max_wait) begin
            proto_errs++;
            $display("data access to %h never got a response", addr);
        end else begin
            assert (data_err == addr[31]) else begin
                value_errs++;
                $display("Fail data_err: got %h expected %h", data_err, addr[31]);
            end
            assert (addr[31] || wen != 4'b0000 || data_rdata == exp) else begin
                value_errs++;
                $display("Fail data_rdata: got %h expected %h", data_rdata, exp);
            end
            if (wen != 4'b0000 && !addr[31]) begin
                for (int i = 0; i < 4; i++) begin
                    if (wen[i]) exp[8*i +: 8] = wdata[8*i +: 8];
                end
                shadow[addr[31:2]] = exp;
            end
        end
        data_en = 1'b0;
    endtask

    // with both heads waiting, a round robin pop switches to the other source.
    always @(posedge aclk) begin
        if (!reset && (mem_subsys_top_inst.fetch_pop || mem_subsys_top_inst.data_pop)) begin
            assert (!(mem_subsys_top_inst.fetch_not_empty && mem_subsys_top_inst.data_not_empty)
                    || mem_subsys_top_inst.data_pop != last_pop) else begin
                proto_errs++;
                $display("arbiter served the same source twice while both were waiting");
            end
            last_pop <= mem_subsys_top_inst.data_pop;
        end
        if (m_arvalid && m_arready) begin
            assert (m_ar.id == id_w'(last_pop)) else begin
                proto_errs++;
                $display("Fail m_ar.id: got %h expected %h", m_ar.id, last_pop);
            end
        end
        if (m_awvalid) begin
            assert (m_aw.size == exp_size) else begin
                value_errs++;
                $display("Fail m_aw.size: got %h expected %h", m_aw.size, exp_size);
            end
            assert (m_aw.id == id_w'(src_data)) else begin
                value_errs++;
                $display("Fail m_aw.id: got %h expected %h", m_aw.id, id_w'(src_data));
            end
        end
        if (m_wvalid) begin
            assert (m_w.strb == exp_wen) else begin
                value_errs++;
                $display("Fail m_w.strb: got %h expected %h", m_w.strb, exp_wen);
            end
        end
        if (!reset) begin
            assert (!(prev_arvalid && !prev_arready)
                    || (m_arvalid && m_ar == prev_ar)) else begin
                proto_errs++;
                $display("Fail m_ar: got %h expected %h", m_ar, prev_ar);
            end
            assert (!(prev_awvalid && !prev_awready)
                    || (m_awvalid && m_aw == prev_aw)) else begin
                proto_errs++;
                $display("Fail m_aw: got %h expected %h", m_aw, prev_aw);
            end
            assert (!(prev_wvalid && !prev_wready)
                    || (m_wvalid && m_w == prev_w)) else begin
                proto_errs++;
                $display("Fail m_w: got %h expected %h", m_w, prev_w);
            end
        end
        prev_arvalid <= m_arvalid;
        prev_arready <= m_arready;
        prev_ar      <= m_ar;
        prev_awvalid <= m_awvalid;
        prev_awready <= m_awready;
        prev_aw      <= m_aw;
        prev_wvalid  <= m_wvalid;
        prev_wready  <= m_wready;
        prev_w       <= m_w;
    end

    initial begin
        #((n_req * max_wait + 40) * 20);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(31));
        value_errs = 0;
        proto_errs = 0;
        last_pop   = src_data;
        reset      = 1'b1;
        inst_en    = 1'b0;
        inst_addr  = '0;
        data_en    = 1'b0;
        data_wen   = '0;
        data_addr  = '0;
        data_wdata = '0;
        data_size  = size_word;
        exp_size   = size_word;
        exp_wen    = '0;
        repeat (10) @(negedge aclk);
        reset = 1'b0;
        repeat (4) begin
            @(negedge aclk);
            assert (!(m_arvalid | m_awvalid | m_wvalid | m_rready | m_bready | inst_stall
                      | data_stall | inst_err | data_err)) else begin
                proto_errs++;
                $display("an output was active after reset with no request");
            end
        end
        fetch_read(rand_addr(32'h0));
        data_access(32'h0000_0900, 4'b1111, 32'h1122_3344, size_word);
        data_access(32'h0000_0901, 4'b0010, 32'h0000_ab00, size_byte);
        data_access(32'h0000_0902, 4'b1100, 32'hcdef_0000, size_half);
        data_access(32'h0000_0900, 4'b0000, 32'h0, size_word);
        fork
            for (int i = 0; i < 8; i++) fetch_read(rand_addr(32'h0));
            for (int i = 0; i < 8; i++) begin
                if ($urandom % 2) data_access(rand_addr(32'h800), 4'b1111, $urandom, size_word);
                else data_access(rand_addr(32'h800), 4'b0000, 32'h0, size_word);
            end
        join
        fetch_read(32'h8000_0040);
        // fetch went last, so the data request has to win this contention.
        fork
            fetch_read(32'h0000_0040);
            data_access(32'h8000_0880, 4'b1111, 32'hdead_beef, size_word);
        join
        data_access(32'h0000_0880, 4'b0000, 32'h0, size_word);
        repeat (4) @(negedge aclk);
        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* src.f */
axi_pkg.sv
core_bus_pkg.sv
req_fifo.sv
fetch_port.sv
data_port.sv
bus_interface.sv
mem_subsys_top.sv
tb_axi_slave.sv
tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - axi_pkg.sv
  - core_bus_pkg.sv
  - req_fifo.sv
  - fetch_port.sv
  - data_port.sv
  - bus_interface.sv
  - mem_subsys_top.sv
  - target: test
    files:
      - tb_axi_slave.sv
      - tb_mem_subsys.sv
